// File: Makefile
TOP = chipset_tb
LOG = sim.log

all: run

run:
	verilator --binary --assert -f sim.f --top-module $(TOP) -o $(TOP)
	./obj_dir/$(TOP) 2>&1 | tee $(LOG)
	grep -q "TEST PASSED" $(LOG)

lint:
	verilator --lint-only --timing --assert -f sim.f --top-module $(TOP)

clean:
	rm -rf obj_dir $(LOG)

.PHONY: all run lint clean

// File: logic/bus_controller.sv
`include "chipset_defines.svh"

module bus_controller import chipset_pkg::*;
(
	input	logic clk,
	input	logic rst,
	mem_bus_if.arbiter cpu,
	mem_bus_if.arbiter dma,
	reg_port_if.host regs,
	output	ram_addr_t ram_addr,
	output	word_t ram_wdata,
	output	logic ram_rd,
	output	logic ram_hwr,
	output	logic ram_lwr,
	input	word_t ram_rdata
);

	localparam logic [23:0] reg_base = `CHIPSET_REG_BASE;

	logic sel_chip;
	logic sel_reg;
	logic cpu_chip;	// CPU owns the bus and targets chip RAM
	logic ret_chip;
	logic ret_reg;

	// The DMA request always wins
	assign dma.grant = dma.req;
	assign cpu.grant = cpu.req && !dma.req;

	assign sel_chip = cpu.addr[23:19] == 5'b0000_0;
	assign sel_reg = cpu.addr[23:3] == reg_base[23:3];
	assign cpu_chip = cpu.grant && sel_chip;

	// DMA addresses only ever point into chip RAM
	assign ram_addr = dma.grant ? dma.addr[18:1] : cpu.addr[18:1];
	assign ram_wdata = dma.grant ? dma.wdata : cpu.wdata;
	assign ram_rd = dma.grant ? dma.rd : cpu_chip && cpu.rd;
	assign ram_hwr = dma.grant ? dma.hwr : cpu_chip && cpu.hwr;
	assign ram_lwr = dma.grant ? dma.lwr : cpu_chip && cpu.lwr;

	assign regs.sel = cpu.grant && sel_reg;
	assign regs.we = cpu.hwr || cpu.lwr;	// Register writes take the whole word
	assign regs.offset = {cpu.addr[2:1], 1'b0};
	assign regs.wdata = cpu.wdata;

	// Remember where the CPU access went so the return cycle picks the right source
	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			ret_chip <= 1'b0;
			ret_reg <= 1'b0;
		end
		else
		begin
			ret_chip <= cpu_chip;
			ret_reg <= regs.sel;
		end
	end

	assign cpu.rdata = ret_chip ? ram_rdata : ret_reg ? regs.rdata : `CHIPSET_UNMAPPED;
	assign dma.rdata = ram_rdata;

endmodule

// File: logic/chip_ram.sv
`include "chipset_defines.svh"

module chip_ram import chipset_pkg::*;
(
	input	logic clk,
	input	ram_addr_t addr,
	input	word_t wdata,
	input	logic rd,
	input	logic hwr,
	input	logic lwr,
	output	word_t rdata
);

	word_t mem [0:`CHIPSET_RAM_WORDS-1];

	always_ff @(posedge clk)
	begin
		if (hwr)
			mem[addr][15:8] <= wdata[15:8];
		if (lwr)
			mem[addr][7:0] <= wdata[7:0];
	end

	// Read data holds until the next read
	always_ff @(posedge clk)
	begin
		if (rd)
			rdata <= mem[addr];
	end

endmodule

// File: logic/chipset_defines.svh
`ifndef CHIPSET_DEFINES_SVH
`define CHIPSET_DEFINES_SVH

// Chip RAM is 512 KB of 16-bit words
`define CHIPSET_RAM_WORDS 262144

`define CHIPSET_REG_BASE 24'hDFF000
`define CHIPSET_UNMAPPED 16'hFFFF

// Byte offsets inside the DMA register window
`define DMA_SRC  3'd0
`define DMA_DST  3'd2
`define DMA_LEN  3'd4
`define DMA_CTRL 3'd6

`endif

// File: logic/chipset_pkg.sv
package chipset_pkg;

	typedef logic [23:1] cpu_addr_t;	// Word address, byte lanes come from the strobes
	typedef logic [17:0] ram_addr_t;
	typedef logic [15:0] word_t;
	typedef logic [15:0] dma_ptr_t;

	typedef enum logic [1:0]
	{
		dma_idle,
		dma_read,
		dma_write,
		dma_gap
	} dma_state_t;

	typedef enum logic [1:0]
	{
		cpu_idle,
		cpu_wait,
		cpu_done
	} cpu_state_t;

endpackage

// File: logic/chipset_top.sv
module chipset_top import chipset_pkg::*;
(
	input	logic clk,
	input	logic rst,
	input	logic [23:0] paddr,
	input	logic psel,
	input	logic penable,
	input	logic pwrite,
	input	logic [1:0] pstrb,
	input	word_t pwdata,
	output	word_t prdata,
	output	logic pready,
	output	logic pslverr
);

	ram_addr_t ram_addr;
	word_t ram_wdata;
	logic ram_rd;
	logic ram_hwr;
	logic ram_lwr;
	word_t ram_rdata;

	mem_bus_if cpu_bus ();
	mem_bus_if dma_bus ();
	reg_port_if reg_port ();

	assign pslverr = 1'b0;	// Every address answers, unmapped ones with all ones

	cpu_bus_port u_cpu_port
	(
		.clk(clk),
		.rst(rst),
		.paddr(paddr),
		.psel(psel),
		.penable(penable),
		.pwrite(pwrite),
		.pstrb(pstrb),
		.pwdata(pwdata),
		.prdata(prdata),
		.pready(pready),
		.bus(cpu_bus)
	);

	dma_copier u_dma
	(
		.clk(clk),
		.rst(rst),
		.regs(reg_port),
		.bus(dma_bus)
	);

	bus_controller u_bus
	(
		.clk(clk),
		.rst(rst),
		.cpu(cpu_bus),
		.dma(dma_bus),
		.regs(reg_port),
		.ram_addr(ram_addr),
		.ram_wdata(ram_wdata),
		.ram_rd(ram_rd),
		.ram_hwr(ram_hwr),
		.ram_lwr(ram_lwr),
		.ram_rdata(ram_rdata)
	);

	chip_ram u_ram
	(
		.clk(clk),
		.addr(ram_addr),
		.wdata(ram_wdata),
		.rd(ram_rd),
		.hwr(ram_hwr),
		.lwr(ram_lwr),
		.rdata(ram_rdata)
	);

endmodule

// File: logic/cpu_bus_port.sv
module cpu_bus_port import chipset_pkg::*;
(
	input	logic clk,
	input	logic rst,
	input	logic [23:0] paddr,
	input	logic psel,
	input	logic penable,
	input	logic pwrite,
	input	logic [1:0] pstrb,
	input	word_t pwdata,
	output	word_t prdata,
	output	logic pready,
	mem_bus_if.master bus
);

	cpu_state_t state;
	logic granted;	// Grant was seen, bus data returns this cycle
	logic access;

	assign access = psel && penable;

	// APB keeps the command stable for the whole access phase
	assign bus.req = (state == cpu_idle && access) || (state == cpu_wait && !granted);
	assign bus.addr = paddr[23:1];
	assign bus.wdata = pwdata;
	assign bus.rd = !pwrite;
	assign bus.hwr = pwrite && pstrb[1];
	assign bus.lwr = pwrite && pstrb[0];

	assign pready = state == cpu_done;

	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			state <= cpu_idle;
			granted <= 1'b0;
		end
		else
		begin
			case (state)
				cpu_idle:
					if (access)
					begin
						state <= cpu_wait;
						granted <= bus.grant;
					end
				cpu_wait:
					if (granted)
						state <= cpu_done;
					else if (bus.grant)
						granted <= 1'b1;
				default:
				begin
					state <= cpu_idle;
					granted <= 1'b0;
				end
			endcase
		end
	end

	always_ff @(posedge clk)
	begin
		if (state == cpu_wait && granted)
			prdata <= bus.rdata;
	end

endmodule

// File: logic/dma_copier.sv
`include "chipset_defines.svh"

module dma_copier import chipset_pkg::*;
(
	input	logic clk,
	input	logic rst,
	reg_port_if.regs regs,
	mem_bus_if.master bus
);

	dma_state_t state;
	dma_ptr_t src;
	dma_ptr_t dst;
	dma_ptr_t len;
	logic busy;
	logic start;

	assign busy = state != dma_idle;
	assign start = regs.sel && regs.we && regs.offset == `DMA_CTRL && regs.wdata[0]
		&& !busy && len != '0;

	assign bus.req = state == dma_read || state == dma_write;
	assign bus.rd = state == dma_read;
	assign bus.hwr = state == dma_write;
	assign bus.lwr = state == dma_write;
	assign bus.addr = {7'b0, (state == dma_write) ? dst : src};
	assign bus.wdata = bus.rdata;	// Source word goes straight back out

	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			state <= dma_idle;
			src <= '0;
			dst <= '0;
			len <= '0;
		end
		else
		begin
			case (state)
				dma_idle:
					if (start)
						state <= dma_read;
				dma_read:
					if (bus.grant)
						state <= dma_write;
				dma_write:
					if (bus.grant)
						state <= (len == 16'd1) ? dma_idle : dma_gap;
				default:
					state <= dma_read;	// Gap cycle leaves the bus to the CPU
			endcase

			// Pointers stay put while a copy runs
			if (regs.sel && regs.we && !busy)
			begin
				case (regs.offset)
					`DMA_SRC: src <= regs.wdata;
					`DMA_DST: dst <= regs.wdata;
					`DMA_LEN: len <= regs.wdata;
					default: ;
				endcase
			end
			else if (state == dma_write && bus.grant)
			begin
				src <= src + 16'd1;
				dst <= dst + 16'd1;
				len <= len - 16'd1;
			end
		end
	end

	always_ff @(posedge clk)
	begin
		if (regs.sel)
		begin
			case (regs.offset)
				`DMA_SRC: regs.rdata <= src;
				`DMA_DST: regs.rdata <= dst;
				`DMA_LEN: regs.rdata <= len;
				default: regs.rdata <= {15'b0, busy};
			endcase
		end
	end

endmodule

// File: logic/mem_bus_if.sv
interface mem_bus_if import chipset_pkg::*;
();
	logic req;
	cpu_addr_t addr;
	word_t wdata;
	logic rd;
	logic hwr;
	logic lwr;
	logic grant;
	word_t rdata;	// Valid the cycle after grant

	modport master
	(
		output req, addr, wdata, rd, hwr, lwr,
		input grant, rdata
	);

	modport arbiter
	(
		input req, addr, wdata, rd, hwr, lwr,
		output grant, rdata
	);

endinterface

// File: logic/reg_port_if.sv
interface reg_port_if import chipset_pkg::*;
();
	logic sel;
	logic we;
	logic [2:0] offset;	// Byte offset, bit 0 always clear
	word_t wdata;
	word_t rdata;

	modport host (output sel, we, offset, wdata, input rdata);

	modport regs (input sel, we, offset, wdata, output rdata);

endinterface

// File: sim.f
+incdir+logic
logic/chipset_pkg.sv
logic/mem_bus_if.sv
logic/reg_port_if.sv
logic/chip_ram.sv
logic/cpu_bus_port.sv
logic/dma_copier.sv
logic/bus_controller.sv
logic/chipset_top.sv
tests/chipset_checker.sv
tests/chipset_tb.sv

// File: tests/chipset_checker.sv
`include "chipset_defines.svh"

module chipset_checker
(
	input	logic clk,
	input	logic rst,
	input	logic psel,
	input	logic penable,
	input	logic pready,
	input	logic cpu_grant,
	input	logic dma_grant,
	input	logic ram_rd,
	input	logic ram_hwr,
	input	logic ram_lwr,
	input	logic busy,
	input	logic reg_sel,
	input	logic reg_we,
	input	logic [2:0] reg_offset
);

	pready_in_access: assert property (@(posedge clk) disable iff (rst)
		$rose(pready) |-> psel && penable)
		else $error("pready rose outside an APB access phase");

	// Only one master may own the chip bus
	one_grant: assert property (@(posedge clk) disable iff (rst)
		!(cpu_grant && dma_grant))
		else $error("CPU and DMA granted in the same cycle");

	ram_needs_grant: assert property (@(posedge clk) disable iff (rst)
		(ram_rd || ram_hwr || ram_lwr) |-> (cpu_grant || dma_grant))
		else $error("Chip RAM enabled with no master granted");

	busy_from_start: assert property (@(posedge clk) disable iff (rst)
		$rose(busy) |-> $past(reg_sel && reg_we && reg_offset == `DMA_CTRL))
		else $error("DMA busy rose without a control register write");

endmodule

bind chipset_top chipset_checker u_checker
(
	.clk(clk),
	.rst(rst),
	.psel(psel),
	.penable(penable),
	.pready(pready),
	.cpu_grant(cpu_bus.grant),
	.dma_grant(dma_bus.grant),
	.ram_rd(ram_rd),
	.ram_hwr(ram_hwr),
	.ram_lwr(ram_lwr),
	.busy(u_dma.busy),
	.reg_sel(reg_port.sel),
	.reg_we(reg_port.we),
	.reg_offset(reg_port.offset)
);

// File: tests/chipset_tb.sv
`include "chipset_defines.svh"

module chipset_tb import chipset_pkg::*;
();
	localparam int clk_period = 40;
	localparam int apb_transfers = 180;	// Estimate with the busy polls included
	localparam int dma_words = 30;
	localparam int timeout_cycles = 200 * apb_transfers + 4 * dma_words;

	logic clk;
	logic rst;
	logic [23:0] paddr;
	logic psel;
	logic penable;
	logic pwrite;
	logic [1:0] pstrb;
	word_t pwdata;
	word_t prdata;
	logic pready;
	logic pslverr;

	logic [31:0] lfsr;
	int checks;
	int errors;
	int test_errors;
	word_t ram_model [ram_addr_t];

	chipset_top DUT (.*);

	function automatic logic [31:0] take_bits(input int n);
		logic [31:0] v;
		v = '0;
		for (int i = 0; i < n; i++)
		begin
			lfsr = lfsr[0] ? (lfsr >> 1) ^ 32'h8020_0003 : lfsr >> 1;
			v = {v[30:0], lfsr[0]};
		end
		return v;
	endfunction

	function automatic logic [23:0] ram_byte(input ram_addr_t a);
		return {5'b0, a, 1'b0};
	endfunction

	function automatic logic [23:0] reg_byte(input logic [2:0] offset);
		return `CHIPSET_REG_BASE | {21'b0, offset};
	endfunction

	// One APB transfer, setup phase then access phase until pready
	task automatic apb_xfer(input logic wr, input logic [23:0] addr, input word_t data,
		input logic [1:0] strb, output word_t rdata);
		@(posedge clk);
		paddr <= addr;
		pwrite <= wr;
		pstrb <= wr ? strb : 2'b00;
		pwdata <= data;
		psel <= 1'b1;
		@(posedge clk);
		penable <= 1'b1;
		do
		begin
			@(posedge clk);
		end
		while (!pready);
		rdata = prdata;
		check_word("pslverr", 16'h0000, {15'b0, pslverr});
		psel <= 1'b0;
		penable <= 1'b0;
	endtask

	task automatic check_word(input string name, input word_t expected, input word_t actual);
		checks++;
		assert (actual === expected)
		else
		begin
			errors++;
			$display("MISMATCH %s expected %h actual %h", name, expected, actual);
		end
	endtask

	task automatic ram_write(input ram_addr_t a, input word_t d, input logic [1:0] strb);
		word_t unused;
		word_t w;
		apb_xfer(1'b1, ram_byte(a), d, strb, unused);
		w = ram_model.exists(a) ? ram_model[a] : '0;
		if (strb[1])
			w[15:8] = d[15:8];
		if (strb[0])
			w[7:0] = d[7:0];
		ram_model[a] = w;
	endtask

	task automatic ram_check(input ram_addr_t a);
		word_t got;
		apb_xfer(1'b0, ram_byte(a), '0, 2'b00, got);
		check_word("prdata", ram_model[a], got);
	endtask

	task automatic reg_read_check(input logic [2:0] offset, input word_t expected);
		word_t got;
		apb_xfer(1'b0, reg_byte(offset), '0, 2'b00, got);
		check_word("prdata", expected, got);
	endtask

	task automatic dma_setup(input dma_ptr_t src, input dma_ptr_t dst, input dma_ptr_t len);
		word_t unused;
		for (int i = 0; i < int'(len); i++)
			ram_write(ram_addr_t'(src) + ram_addr_t'(i), word_t'(take_bits(16)), 2'b11);
		// The word just past the destination block must survive the copy
		ram_write(ram_addr_t'(dst) + ram_addr_t'(len), word_t'(take_bits(16)), 2'b11);
		apb_xfer(1'b1, reg_byte(`DMA_SRC), src, 2'b11, unused);
		apb_xfer(1'b1, reg_byte(`DMA_DST), dst, 2'b11, unused);
		apb_xfer(1'b1, reg_byte(`DMA_LEN), len, 2'b11, unused);
	endtask

	// Words move in ascending order, so an overlapping copy sees earlier results
	task automatic dma_finish(input dma_ptr_t src, input dma_ptr_t dst, input dma_ptr_t len);
		word_t status;
		status = 16'h0001;
		while (status[0])
			apb_xfer(1'b0, reg_byte(`DMA_CTRL), '0, 2'b00, status);
		for (int i = 0; i < int'(len); i++)
			ram_model[ram_addr_t'(dst) + ram_addr_t'(i)] =
				ram_model[ram_addr_t'(src) + ram_addr_t'(i)];
		for (int i = 0; i < int'(len) + 1; i++)
			ram_check(ram_addr_t'(dst) + ram_addr_t'(i));
	endtask

	task automatic end_test(input string name);
		$display("Test %s finished with %0d errors", name, errors - test_errors);
		test_errors = errors;
	endtask

	initial
	begin
		clk = 1'b0;
		forever #(clk_period / 2) clk = ~clk;
	end

	initial
	begin
		repeat (timeout_cycles) @(posedge clk);
		$display("Timeout after %0d cycles, the tests did not finish", timeout_cycles);
		$display("TEST FAILED");
		$finish;
	end

	initial
	begin
		word_t got;
		ram_addr_t addrs [8];
		lfsr = 32'h40b1;
		checks = 0;
		errors = 0;
		test_errors = 0;
		rst = 1'b1;
		paddr = '0;
		psel = 1'b0;
		penable = 1'b0;
		pwrite = 1'b0;
		pstrb = 2'b00;
		pwdata = '0;
		repeat (3) @(posedge clk);
		rst <= 1'b0;

		check_word("pready", 16'h0000, {15'b0, pready});
		reg_read_check(`DMA_CTRL, 16'h0000);
		end_test("reset");

		// Test words sit above the 64K words the DMA pointers can reach
		for (int i = 0; i < 8; i++)
		begin
			addrs[i] = ram_addr_t'(18'h20000 | take_bits(12));
			ram_write(addrs[i], word_t'(take_bits(16)), 2'b11);
		end
		for (int i = 0; i < 8; i++)
			ram_check(addrs[i]);
		for (int i = 0; i < 8; i++)
			ram_write(addrs[i], word_t'(take_bits(16)), (take_bits(1) != 0) ? 2'b10 : 2'b01);
		for (int i = 0; i < 8; i++)
			ram_check(addrs[i]);
		end_test("chip RAM");

		apb_xfer(1'b0, 24'hE00000, '0, 2'b00, got);
		check_word("prdata", `CHIPSET_UNMAPPED, got);
		apb_xfer(1'b0, `CHIPSET_REG_BASE + 24'h8, '0, 2'b00, got);
		check_word("prdata", `CHIPSET_UNMAPPED, got);
		apb_xfer(1'b1, ram_byte(addrs[0]) | 24'h080000, ~ram_model[addrs[0]], 2'b11, got);
		ram_check(addrs[0]);
		end_test("unmapped");

		dma_setup(16'h0100, 16'h0200, 16'd8);
		reg_read_check(`DMA_SRC, 16'h0100);
		reg_read_check(`DMA_DST, 16'h0200);
		reg_read_check(`DMA_LEN, 16'd8);
		apb_xfer(1'b1, reg_byte(`DMA_CTRL), 16'h0001, 2'b11, got);
		dma_finish(16'h0100, 16'h0200, 16'd8);
		dma_setup(16'h0300, 16'h0301, 16'd6);
		apb_xfer(1'b1, reg_byte(`DMA_CTRL), 16'h0001, 2'b11, got);
		dma_finish(16'h0300, 16'h0301, 16'd6);
		end_test("DMA copy");

		dma_setup(16'h0400, 16'h0500, 16'd16);
		apb_xfer(1'b1, reg_byte(`DMA_CTRL), 16'h0001, 2'b11, got);
		ram_write(addrs[1], word_t'(take_bits(16)), 2'b11);
		ram_check(addrs[1]);
		reg_read_check(`DMA_CTRL, 16'h0001);
		apb_xfer(1'b1, reg_byte(`DMA_CTRL), 16'h0001, 2'b11, got);	// Lands while busy
		dma_finish(16'h0400, 16'h0500, 16'd16);
		reg_read_check(`DMA_SRC, 16'h0410);
		reg_read_check(`DMA_LEN, 16'h0000);
		reg_read_check(`DMA_CTRL, 16'h0000);
		end_test("access during DMA");

		$display("Checks %0d, errors %0d", checks, errors);
		if (errors == 0)
			$display("TEST PASSED");
		else
			$display("TEST FAILED");
		$finish;
	end

endmodule
